/* logic/jsp_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// JTAG serial port shared definitions
// FIFO command and status words, the UART bus word layout and constants
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package jsp_pkg;

  localparam int CNT_W = 4;              // FIFO fill count width

  typedef logic [7:0]       byte_t;
  typedef logic [CNT_W-1:0] cnt_t;

  // Controller to FIFO
  typedef struct packed {
    logic en;                            // Operate this cycle
    logic push_popn;                     // High push, low pop
  } fifo_cmd_t;

  // FIFO to controller
  typedef struct packed {
    byte_t head;                         // Oldest byte in the buffer
    cnt_t  avail;                        // Bytes held
    cnt_t  free;                         // Slots left
  } fifo_stat_t;

  // Lower bus word, address bit 2 clear
  typedef struct packed {
    byte_t      data;                    // RBR on read, THR on write
    logic [3:0] ier_pad;
    logic [3:0] ier;
    byte_t      iir_fcr;                 // IIR on read, FCR on write
    byte_t      lcr;
  } lo_word_t;

  // Upper bus word, address bit 2 set
  typedef struct packed {
    byte_t mcr;
    byte_t lsr;
    byte_t msr;
    byte_t scr;
  } hi_word_t;

  // One bus word, two decodes picked by address bit 2
  typedef union packed {
    lo_word_t lo;
    hi_word_t hi;
  } uart_word_u;

  localparam logic [6:0] LCR_8N1   = 7'h03;   // 8 data bits, no parity, 1 stop
  localparam byte_t      MSR_CONST = 8'hB0;   // CD, DSR and CTS up, RI down

  // Interrupt identification codes
  localparam logic [2:0] IIR_NONE = 3'b001;
  localparam logic [2:0] IIR_THRE = 3'b010;
  localparam logic [2:0] IIR_RDA  = 3'b100;

  // FCR flush bits as bus bit positions
  localparam int FCR_RX_RST_BIT = 9;
  localparam int FCR_TX_RST_BIT = 10;

endpackage

`default_nettype wire

/* logic/jsp_byte_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// Byte FIFO
// Circular buffer, one push or pop per enabled cycle, reports fill counts
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module jsp_byte_fifo #(
  parameter int FIFO_DEPTH = 8                   // 2 to 15
) (
  input  wire                     wb_clk_i,
  input  wire                     rst_i,
  input  wire                     clr_i,         // Synchronous flush
  input  wire jsp_pkg::fifo_cmd_t cmd_i,
  input  wire jsp_pkg::byte_t     data_i,
  output jsp_pkg::fifo_stat_t     stat_o
);
  import jsp_pkg::*;

  localparam int               PTR_W = $clog2(FIFO_DEPTH);
  localparam logic [PTR_W-1:0] LAST  = PTR_W'(FIFO_DEPTH - 1);   // Wrap point

  byte_t            mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  cnt_t             count;
  logic             do_push;
  logic             do_pop;

  // Full and empty guards
  assign do_push = cmd_i.en &  cmd_i.push_popn & (count != cnt_t'(FIFO_DEPTH));
  assign do_pop  = cmd_i.en & ~cmd_i.push_popn & (count != '0);

  always_ff @(posedge wb_clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clr_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (do_push) begin
      wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      count  <= count + 1'b1;
    end else if (do_pop) begin
      rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      count  <= count - 1'b1;
    end
  end

  assign stat_o = '{head: mem[rd_ptr], avail: count, free: cnt_t'(FIFO_DEPTH) - count};

  // Controllers must respect the fill level they were shown
  a_no_overflow : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    cmd_i.en && cmd_i.push_popn |-> count != cnt_t'(FIFO_DEPTH))
    else $error("push into full FIFO");
  a_no_underflow : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    cmd_i.en && !cmd_i.push_popn |-> count != '0)
    else $error("pop from empty FIFO");

endmodule

`default_nettype wire

/* logic/jsp_clock_crossing.sv */
////////////////////////////////////////////////////////////////////////////
// JTAG to Wishbone clock crossing
// TCK strobe capture, toggle-to-level detectors and count synchronizers
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module jsp_clock_crossing (
  input  wire                 tck_i,
  input  wire                 wb_clk_i,
  input  wire                 rst_i,
  input  wire jsp_pkg::byte_t data_i,
  input  wire                 wr_strobe_i,
  input  wire                 rd_strobe_i,
  input  wire                 wda_clr_i,          // From receive controller
  input  wire                 pop_clr_i,          // From transmit controller
  input  wire jsp_pkg::cnt_t  rx_free_i,
  input  wire jsp_pkg::cnt_t  tx_avail_i,
  output jsp_pkg::byte_t      wr_data_o,
  output logic                wdata_avail_o,
  output logic                pop_req_o,
  output jsp_pkg::cnt_t       bytes_free_o,
  output jsp_pkg::cnt_t       bytes_available_o
);
  import jsp_pkg::*;

  // Index 0 carries the write path and index 1 the read path
  logic [1:0] tog_q;
  logic [1:0] sync1_q;
  logic [1:0] sync2_q;
  logic [1:0] sync3_q;
  logic [1:0] level_q;
  logic [1:0] clr;
  cnt_t       free_meta_q;
  cnt_t       avail_meta_q;

  ////////////////////////////////////////////////////////////////////////////
  // TCK domain
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      tog_q <= '0;
    end else begin
      tog_q <= tog_q ^ {rd_strobe_i, wr_strobe_i};   // Flip once per strobe
    end
  end

  // Byte held until the next write strobe
  always_ff @(posedge tck_i) begin
    if (wr_strobe_i) begin
      wr_data_o <= data_i;
    end
  end

  // Counts back to TCK
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      free_meta_q       <= '0;
      bytes_free_o      <= '0;
      avail_meta_q      <= '0;
      bytes_available_o <= '0;
    end else begin
      free_meta_q       <= rx_free_i;
      bytes_free_o      <= free_meta_q;
      avail_meta_q      <= tx_avail_i;
      bytes_available_o <= avail_meta_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone domain
  assign clr = {pop_clr_i, wda_clr_i};

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      sync3_q <= '0;
      level_q <= '0;
    end else begin
      sync1_q <= tog_q;                            // Metastability stage
      sync2_q <= sync1_q;
      sync3_q <= sync2_q;
      level_q <= (level_q & ~clr) | (sync2_q ^ sync3_q);   // New edge wins over clear
    end
  end

  assign wdata_avail_o = level_q[0];
  assign pop_req_o     = level_q[1];

endmodule

`default_nettype wire

/* logic/jsp_rx_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Receive controller
// Pushes JTAG bytes into the receive FIFO and pops them for CPU reads
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module jsp_rx_ctrl (
  input  wire                wb_clk_i,
  input  wire                rst_i,
  input  wire                wdata_avail_i,     // JTAG byte waiting
  input  wire                fifo_rd_i,         // CPU data read
  output logic               wda_clr_o,
  output jsp_pkg::fifo_cmd_t cmd_o,
  output logic               ack_o
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_PUSH = 2'd1;
  localparam logic [1:0] ST_POP  = 2'd2;

  logic [1:0] state_q;
  logic [1:0] state_d;

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // CPU read goes ahead of a waiting JTAG byte
  always_comb begin
    state_d = ST_IDLE;
    case (state_q)
      ST_IDLE: begin
        if (fifo_rd_i) state_d = ST_POP;
        else if (wdata_avail_i) state_d = ST_PUSH;
      end
      ST_PUSH: if (fifo_rd_i) state_d = ST_POP;
      ST_POP:  if (wdata_avail_i) state_d = ST_PUSH;   // Bus drops its request here
      default: state_d = ST_IDLE;
    endcase
  end

  assign wda_clr_o = (state_q == ST_PUSH);   // Consume the availability level
  assign ack_o     = (state_q == ST_POP);    // Head is still valid this cycle
  assign cmd_o     = '{en: wda_clr_o | ack_o, push_popn: wda_clr_o};

  a_state_legal : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    state_q != 2'd3)
    else $error("receive controller in unused state");

endmodule

`default_nettype wire

/* logic/jsp_tx_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Transmit controller
// Pushes CPU bytes, pops toward JTAG and latches the byte shown on data_o
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module jsp_tx_ctrl (
  input  wire                 wb_clk_i,
  input  wire                 rst_i,
  input  wire                 fifo_wr_i,        // CPU data write
  input  wire                 pop_req_i,        // Host took data_o
  input  wire                 debug_select_i,   // Low drains the FIFO
  input  wire jsp_pkg::fifo_stat_t stat_i,
  output jsp_pkg::fifo_cmd_t  cmd_o,
  output logic                pop_clr_o,
  output logic                ack_o,
  output logic                becoming_empty_o,
  output jsp_pkg::byte_t      data_o
);
  import jsp_pkg::*;

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_PUSH  = 2'd1;
  localparam logic [1:0] ST_POP   = 2'd2;
  localparam logic [1:0] ST_LATCH = 2'd3;

  logic [1:0] state_q;
  logic [1:0] state_d;
  logic       empty;
  logic       pop_want;

  assign empty    = (stat_i.avail == '0);
  assign pop_want = (pop_req_i | ~debug_select_i) & ~empty;   // Host asked or host absent

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = ST_IDLE;
    case (state_q)
      ST_IDLE, ST_LATCH: begin
        if (fifo_wr_i) state_d = ST_PUSH;
        else if (pop_want) state_d = ST_POP;
      end
      ST_PUSH: begin
        if (empty) state_d = ST_LATCH;              // First byte goes straight out
        else if (pop_want) state_d = ST_POP;
      end
      ST_POP:  state_d = ST_LATCH;                  // New head to data_o
      default: state_d = ST_IDLE;
    endcase
  end

  assign ack_o            = (state_q == ST_PUSH);
  assign pop_clr_o        = (state_q == ST_POP);
  assign cmd_o            = '{en: ack_o | pop_clr_o, push_popn: ack_o};
  assign becoming_empty_o = pop_clr_o & (stat_i.avail == cnt_t'(1));   // Last byte leaving

  // Output byte for the JTAG side
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      data_o <= '0;
    end else if (state_q == ST_LATCH) begin
      data_o <= stat_i.head;
    end
  end

endmodule

`default_nettype wire

/* logic/jsp_uart_regs.sv */
////////////////////////////////////////////////////////////////////////////
// 16550 style register block
// Address decode, FIFO requests, read mux, FCR flushes and interrupt
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module jsp_uart_regs #(
  parameter int FIFO_DEPTH = 8
) (
  input  wire                 wb_clk_i,
  input  wire                 rst_i,
  input  wire [31:0]          wb_adr_i,
  input  wire [31:0]          wb_dat_i,
  input  wire [3:0]           wb_sel_i,
  input  wire                 wb_we_i,
  input  wire                 wb_cyc_i,
  input  wire                 wb_stb_i,
  input  wire                 rx_ack_i,
  input  wire                 tx_ack_i,
  input  wire jsp_pkg::byte_t rx_head_i,
  input  wire jsp_pkg::cnt_t  rx_avail_i,
  input  wire jsp_pkg::cnt_t  tx_avail_i,
  input  wire                 tx_becoming_empty_i,
  output logic [31:0]         wb_dat_o,
  output logic                wb_ack_o,
  output logic                int_o,
  output logic                fifo_rd_o,
  output logic                fifo_wr_o,
  output logic                rx_fifo_clr_o,
  output logic                tx_fifo_clr_o
);
  import jsp_pkg::*;

  logic       bus_req;
  logic       lo_sel;          // Address bit 2 clear
  logic       fifo_access;     // Data lane of the lower word
  logic       reg_ack;
  logic       dlab_wr;
  logic       ier_wr;
  logic       fcr_wr;
  logic       iir_rd;
  logic       dlab_q;
  logic [3:0] ier_q;
  logic       thre_arm_q;      // Lets an IIR read retire the THRE interrupt
  logic       rx_not_empty;
  logic       tx_not_full;
  logic [2:0] reg_iir;
  byte_t      reg_lsr;
  lo_word_t   wr_lo;
  uart_word_u rd_word;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  assign bus_req     = wb_cyc_i & wb_stb_i;
  assign lo_sel      = ~wb_adr_i[2];
  assign fifo_access = lo_sel & wb_sel_i[3];
  assign wr_lo       = wb_dat_i;

  assign fifo_rd_o = bus_req & ~wb_we_i & fifo_access & ~dlab_q;
  assign fifo_wr_o = bus_req &  wb_we_i & fifo_access & ~dlab_q;
  assign reg_ack   = bus_req & (|wb_sel_i) & (dlab_q | ~fifo_access);   // Same cycle
  assign wb_ack_o  = reg_ack | rx_ack_i | tx_ack_i;

  assign dlab_wr = bus_req &  wb_we_i & lo_sel & wb_sel_i[0];
  assign ier_wr  = bus_req &  wb_we_i & lo_sel & wb_sel_i[2] & ~dlab_q;
  assign fcr_wr  = bus_req &  wb_we_i & lo_sel & wb_sel_i[1];
  assign iir_rd  = bus_req & ~wb_we_i & lo_sel & wb_sel_i[1];

  assign rx_fifo_clr_o = fcr_wr & wb_dat_i[FCR_RX_RST_BIT];
  assign tx_fifo_clr_o = fcr_wr & wb_dat_i[FCR_TX_RST_BIT];

  ////////////////////////////////////////////////////////////////////////////
  // Registers and status
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      dlab_q     <= 1'b0;
      ier_q      <= '0;
      thre_arm_q <= 1'b0;
    end else begin
      if (dlab_wr) dlab_q <= wr_lo.lcr[7];
      if (ier_wr) ier_q <= wr_lo.ier;
      if (fifo_wr_o | tx_becoming_empty_i) begin
        thre_arm_q <= 1'b1;                        // Armed by a write or a drain
      end else if (iir_rd & ~rx_not_empty) begin
        thre_arm_q <= 1'b0;
      end
    end
  end

  assign rx_not_empty = (rx_avail_i != '0);
  assign tx_not_full  = (tx_avail_i != cnt_t'(FIFO_DEPTH));
  assign reg_lsr      = {1'b0, tx_not_full, tx_not_full, 4'b0000, rx_not_empty};

  // Receive data outranks an armed THRE
  always_comb begin
    if (rx_not_empty) reg_iir = IIR_RDA;
    else if (thre_arm_q & tx_not_full) reg_iir = IIR_THRE;
    else reg_iir = IIR_NONE;
  end

  // All four lanes driven, master picks its bytes
  always_comb begin
    if (wb_adr_i[2]) begin
      rd_word.hi = '{mcr: 8'h00, lsr: reg_lsr, msr: MSR_CONST, scr: 8'h00};
    end else begin
      rd_word.lo = '{data: rx_head_i, ier_pad: 4'h0, ier: ier_q,
                     iir_fcr: {5'b00000, reg_iir}, lcr: {dlab_q, LCR_8N1}};
    end
  end

  assign wb_dat_o = rd_word;
  assign int_o    = (tx_not_full & thre_arm_q & ier_q[1]) | (rx_not_empty & ier_q[0]);

  // Controller acks only land inside a live bus cycle
  a_ack_in_cycle : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    wb_ack_o |-> bus_req)
    else $error("acknowledge outside a bus cycle");

endmodule

`default_nettype wire

/* logic/jsp_biu_top.sv */
////////////////////////////////////////////////////////////////////////////
// JTAG serial port bus interface
// Debug host and Wishbone CPU swap bytes through two FIFOs behind a 16550 face
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module jsp_biu_top #(
  parameter int FIFO_DEPTH = 8
) (
  // JTAG side
  input  wire                 tck_i,
  input  wire                 rst_i,
  input  wire jsp_pkg::byte_t data_i,
  output jsp_pkg::byte_t      data_o,
  output jsp_pkg::cnt_t       bytes_free_o,        // Receive FIFO room
  output jsp_pkg::cnt_t       bytes_available_o,   // Transmit FIFO fill
  input  wire                 rd_strobe_i,
  input  wire                 wr_strobe_i,
  input  wire                 debug_select_i,
  // Wishbone side
  input  wire                 wb_clk_i,
  input  wire [31:0]          wb_adr_i,
  output logic [31:0]         wb_dat_o,
  input  wire [31:0]          wb_dat_i,
  input  wire                 wb_cyc_i,
  input  wire                 wb_stb_i,
  input  wire [3:0]           wb_sel_i,
  input  wire                 wb_we_i,
  output logic                wb_ack_o,
  output logic                int_o
);
  import jsp_pkg::*;

  byte_t      wr_data;
  logic       wdata_avail;
  logic       pop_req;
  logic       wda_clr;
  logic       pop_clr;
  logic       fifo_rd;
  logic       fifo_wr;
  logic       rx_ack;
  logic       tx_ack;
  logic       tx_becoming_empty;
  logic       rx_fifo_clr;
  logic       tx_fifo_clr;
  fifo_cmd_t  rx_cmd;
  fifo_cmd_t  tx_cmd;
  fifo_stat_t rx_stat;
  fifo_stat_t tx_stat;

  jsp_clock_crossing clock_crossing (
    .tck_i(tck_i), .wb_clk_i(wb_clk_i), .rst_i(rst_i),
    .data_i(data_i), .wr_strobe_i(wr_strobe_i), .rd_strobe_i(rd_strobe_i),
    .wda_clr_i(wda_clr), .pop_clr_i(pop_clr),
    .rx_free_i(rx_stat.free), .tx_avail_i(tx_stat.avail),
    .wr_data_o(wr_data), .wdata_avail_o(wdata_avail), .pop_req_o(pop_req),
    .bytes_free_o(bytes_free_o), .bytes_available_o(bytes_available_o)
  );

  // JTAG to CPU
  jsp_byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo (
    .wb_clk_i(wb_clk_i), .rst_i(rst_i), .clr_i(rx_fifo_clr),
    .cmd_i(rx_cmd), .data_i(wr_data), .stat_o(rx_stat)
  );

  // CPU to JTAG, data from byte lane 3
  jsp_byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo (
    .wb_clk_i(wb_clk_i), .rst_i(rst_i), .clr_i(tx_fifo_clr),
    .cmd_i(tx_cmd), .data_i(wb_dat_i[31:24]), .stat_o(tx_stat)
  );

  jsp_rx_ctrl rx_ctrl (
    .wb_clk_i(wb_clk_i), .rst_i(rst_i), .wdata_avail_i(wdata_avail),
    .fifo_rd_i(fifo_rd), .wda_clr_o(wda_clr), .cmd_o(rx_cmd), .ack_o(rx_ack)
  );

  jsp_tx_ctrl tx_ctrl (
    .wb_clk_i(wb_clk_i), .rst_i(rst_i), .fifo_wr_i(fifo_wr), .pop_req_i(pop_req),
    .debug_select_i(debug_select_i), .stat_i(tx_stat), .cmd_o(tx_cmd),
    .pop_clr_o(pop_clr), .ack_o(tx_ack), .becoming_empty_o(tx_becoming_empty),
    .data_o(data_o)
  );

  jsp_uart_regs #(.FIFO_DEPTH(FIFO_DEPTH)) uart_regs (
    .wb_clk_i(wb_clk_i), .rst_i(rst_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
    .wb_sel_i(wb_sel_i), .wb_we_i(wb_we_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
    .rx_ack_i(rx_ack), .tx_ack_i(tx_ack), .rx_head_i(rx_stat.head),
    .rx_avail_i(rx_stat.avail), .tx_avail_i(tx_stat.avail),
    .tx_becoming_empty_i(tx_becoming_empty), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .int_o(int_o), .fifo_rd_o(fifo_rd), .fifo_wr_o(fifo_wr),
    .rx_fifo_clr_o(rx_fifo_clr), .tx_fifo_clr_o(tx_fifo_clr)
  );

endmodule

`default_nettype wire

/* testbench/tb_jsp_checks.svh */
////////////////////////////////////////////////////////////////////////////
// Testbench checks
// Reference byte queues, value checks and bus protocol assertions
////////////////////////////////////////////////////////////////////////////
`ifndef TB_JSP_CHECKS_SVH
`define TB_JSP_CHECKS_SVH

  byte_t tx_q[$];                  // CPU bytes not yet taken by the host
  byte_t rx_q[$];                  // Host bytes not yet read by the CPU
  int    check_errs  = 0;
  int    assert_errs = 0;

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else begin
      check_errs++;
      $display("FAIL at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      check_errs++;
      $display("FAIL at %0t ns: %s", $time, what);
    end
  endtask

  // Acknowledge only inside a strobed cycle
  a_ack_in_cycle : assert property (@(posedge wb_clk_i) disable iff (rst_i)
    wb_ack_o |-> wb_cyc_i && wb_stb_i)
    else begin
      assert_errs++;
      $display("FAIL at %0t ns: acknowledge without a bus cycle", $time);
    end

  // Host side shows the model head whenever bytes wait
  a_head_order : assert property (@(negedge wb_clk_i) disable iff (rst_i)
    (bytes_available_o == cnt_t'(tx_q.size())) && tx_q.size() != 0 |-> data_o == tx_q[0])
    else begin
      assert_errs++;
      $display("FAIL at %0t ns: data_o out of order", $time);
    end

`endif

/* testbench/tb_jsp_biu.sv */
////////////////////////////////////////////////////////////////////////////
// JTAG serial port testbench
// Bus and JTAG stimulus against byte queue reference model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_jsp_biu;
  import jsp_pkg::*;

  localparam int DEPTH   = 8;
  localparam int TIMEOUT = 20000;          // wb cycles

  logic        wb_clk_i = 1'b0;
  logic        tck_i    = 1'b0;
  logic        rst_i    = 1'b1;
  byte_t       data_i   = '0;
  logic        rd_strobe_i = 1'b0;
  logic        wr_strobe_i = 1'b0;
  logic        debug_select_i = 1'b1;
  logic [31:0] wb_adr_i = '0;
  logic [31:0] wb_dat_i = '0;
  logic        wb_cyc_i = 1'b0;
  logic        wb_stb_i = 1'b0;
  logic [3:0]  wb_sel_i = '0;
  logic        wb_we_i  = 1'b0;
  byte_t       data_o;
  cnt_t        bytes_free_o;
  cnt_t        bytes_available_o;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        int_o;
  logic [31:0] rd;
  int          lat;
  int          cycles = 0;
  integer      seed = 32'h1b0edb3f;

  `include "tb_jsp_checks.svh"

  jsp_biu_top #(.FIFO_DEPTH(DEPTH)) jsp_biu_top_inst (.*);

  always #10 wb_clk_i = ~wb_clk_i;
  always #17 tck_i = ~tck_i;           // Unrelated to the bus clock

  always @(posedge wb_clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout: run still busy after %0d bus cycles", TIMEOUT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Bus and JTAG tasks
  task automatic bus_cycle(input logic [31:0] adr, input logic we, input logic [3:0] sel,
                           input logic [31:0] dat, output logic [31:0] rdat, output int n);
    @(negedge wb_clk_i);
    {wb_adr_i, wb_we_i, wb_sel_i, wb_dat_i} = {adr, we, sel, dat};
    {wb_cyc_i, wb_stb_i} = 2'b11;
    n = 0;
    #1;
    while (!wb_ack_o) begin                // Hold until acknowledged
      @(negedge wb_clk_i);
      #1;
      n++;
    end
    rdat = wb_dat_o;
    @(negedge wb_clk_i);                   // Transfer done at the edge in between
    {wb_cyc_i, wb_stb_i, wb_we_i} = 3'b000;
  endtask

  task automatic cpu_write_byte(input byte_t b);
    bus_cycle(32'h0, 1'b1, 4'b1000, {b, 24'h0}, rd, lat);
    check_true(lat >= 1 && lat <= 2, "FIFO write ack latency");
    tx_q.push_back(b);
  endtask

  task automatic cpu_read_byte();
    bus_cycle(32'h0, 1'b0, 4'b1000, 32'h0, rd, lat);
    check_true(lat >= 1 && lat <= 2, "FIFO read ack latency");
    check_eq(rd[31:24], rx_q.pop_front(), "received byte");
  endtask

  // Wait for both host-side counts to match the model
  task automatic settle_counts();
    while (bytes_available_o != cnt_t'(tx_q.size()) ||
           bytes_free_o != cnt_t'(DEPTH - rx_q.size())) @(negedge wb_clk_i);
  endtask

  task automatic jtag_write(input byte_t b);
    @(negedge tck_i);
    data_i = b;
    wr_strobe_i = 1'b1;
    @(negedge tck_i);
    wr_strobe_i = 1'b0;
    rx_q.push_back(b);
    settle_counts();
  endtask

  task automatic jtag_read();
    @(negedge tck_i);
    rd_strobe_i = 1'b1;
    @(negedge tck_i);
    rd_strobe_i = 1'b0;
    void'(tx_q.pop_front());
    settle_counts();
  endtask

  task automatic check_lsr_rx(input logic exp);
    bus_cycle(32'h4, 1'b0, 4'b0100, 32'h0, rd, lat);
    check_eq(rd[16], exp, "LSR data ready");
  endtask

  task automatic check_iir(input logic [2:0] exp);
    bus_cycle(32'h0, 1'b0, 4'b0010, 32'h0, rd, lat);
    check_eq(rd[10:8], exp, "IIR");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  initial begin
    repeat (3) @(posedge wb_clk_i);
    @(negedge wb_clk_i) rst_i = 1'b0;

    // After reset
    check_eq({int_o, wb_ack_o, bytes_available_o}, '0, "idle outputs");
    settle_counts();
    bus_cycle(32'h0, 1'b0, 4'b0111, 32'h0, rd, lat);
    check_eq({rd[10:8], rd[7:0]}, {3'b001, 8'h03}, "IIR and LCR");
    check_eq(lat, 0, "register ack latency");
    bus_cycle(32'h4, 1'b0, 4'b1111, 32'h0, rd, lat);
    check_eq(rd[23:8], 16'h60B0, "LSR and MSR");

    // CPU to JTAG, then drain with the host gone
    repeat (5) cpu_write_byte(byte_t'($random(seed)));
    settle_counts();
    repeat (3) jtag_read();
    debug_select_i = 1'b0;
    tx_q.delete();
    settle_counts();
    debug_select_i = 1'b1;

    // JTAG to CPU
    repeat (4) jtag_write(byte_t'($random(seed)));
    check_lsr_rx(1'b1);
    repeat (4) cpu_read_byte();
    check_lsr_rx(1'b0);

    // DLAB set, lane 3 turns into a plain register
    bus_cycle(32'h0, 1'b1, 4'b0001, 32'h83, rd, lat);
    bus_cycle(32'h0, 1'b1, 4'b1000, 32'h5A00_0000, rd, lat);
    check_eq(lat, 0, "DLAB write ack latency");
    bus_cycle(32'h0, 1'b0, 4'b1000, 32'h0, rd, lat);
    check_eq(lat, 0, "DLAB read ack latency");
    bus_cycle(32'h0, 1'b1, 4'b0100, 32'h0003_0000, rd, lat);
    repeat (10) @(negedge wb_clk_i);
    check_eq({bytes_available_o, bytes_free_o}, {4'd0, 4'd8}, "counts under DLAB");
    bus_cycle(32'h0, 1'b1, 4'b0001, 32'h03, rd, lat);
    bus_cycle(32'h0, 1'b0, 4'b0100, 32'h0, rd, lat);
    check_eq(rd[19:16], 4'h0, "IER after DLAB write");

    // Receive data interrupt
    bus_cycle(32'h0, 1'b1, 4'b0100, 32'h0001_0000, rd, lat);
    jtag_write(byte_t'($random(seed)));
    check_true(int_o, "int_o with receive data");
    check_iir(IIR_RDA);
    cpu_read_byte();
    // Transmit empty interrupt after a drain
    bus_cycle(32'h0, 1'b1, 4'b0100, 32'h0002_0000, rd, lat);
    cpu_write_byte(byte_t'($random(seed)));
    settle_counts();                       // Byte visible to the host first
    check_iir(IIR_THRE);                   // Write armed it, this read retires it
    check_true(!int_o, "int_o with a byte waiting");
    debug_select_i = 1'b0;
    tx_q.delete();
    settle_counts();
    check_true(int_o, "int_o after drain");
    check_iir(IIR_THRE);
    check_iir(IIR_NONE);
    check_true(!int_o, "int_o after IIR read");
    debug_select_i = 1'b1;

    // FCR flushes
    repeat (3) cpu_write_byte(byte_t'($random(seed)));
    repeat (2) jtag_write(byte_t'($random(seed)));
    bus_cycle(32'h0, 1'b1, 4'b0010, 32'h200, rd, lat);
    rx_q.delete();
    settle_counts();
    check_lsr_rx(1'b0);
    bus_cycle(32'h0, 1'b1, 4'b0010, 32'h400, rd, lat);
    tx_q.delete();
    settle_counts();

    repeat (4) @(negedge wb_clk_i);
    $display("Errors: checks %0d, assertions %0d", check_errs, assert_errs);
    if (check_errs == 0 && assert_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
logic/jsp_pkg.sv
logic/jsp_byte_fifo.sv
logic/jsp_clock_crossing.sv
logic/jsp_rx_ctrl.sv
logic/jsp_tx_ctrl.sv
logic/jsp_uart_regs.sv
logic/jsp_biu_top.sv
+incdir+testbench
testbench/tb_jsp_biu.sv

/* run.sh */
#!/bin/sh
# Build and run the JTAG serial port testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module tb_jsp_biu -Mdir obj_dir \
  && ./obj_dir/Vtb_jsp_biu > sim.log 2>&1
[ -f sim.log ] && cat sim.log
grep -qx "PASS: all tests" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
